// File: Makefile
# Verilator build and run for the signed multiply subsystem
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= imul_tb
RTL_TOP   ?= imul_top
FILELIST  ?= imul.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
FAIL_MSG  ?= ** FAIL **

RTL_SRCS  ?= imul_pkg.sv imul_req_queue.sv imul_iter_ctrl.sv \
             imul_iter_dpath.sv imul_iter_mul.sv imul_top.sv

SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) --lint-only --assert --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: imul.f
imul_pkg.sv
imul_req_queue.sv
imul_iter_ctrl.sv
imul_iter_dpath.sv
imul_iter_mul.sv
imul_top.sv
imul_tb.sv

// File: imul_iter_ctrl.sv
// control unit of the iterative multiplier
// sequences load, MUL_STEPS shift cycles and the response hold
module imul_iter_ctrl
  import imul_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // request side handshake
  input  logic q_val,
  output logic q_rdy,

  // response side handshake
  output logic resp_val,
  input  logic resp_rdy,

  // datapath controls
  output logic load,
  output logic shift
);

  mul_state_e state;
  mul_state_e state_next;
  step_t      step;

  logic       accept;
  logic       resp_done;
  logic       last_step;

  // ------------------------------
  // output decode
  // ------------------------------
  assign q_rdy    = (state == IDLE);
  assign resp_val = (state == DONE);
  assign shift    = (state == CALC);

  assign accept    = q_val && q_rdy;
  assign resp_done = resp_val && resp_rdy;
  assign last_step = (step == step_t'(MUL_STEPS - 1));

  // operands captured only on the transfer edge
  assign load = accept;

  // next state
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = CALC;
        end
      end
      CALC: begin
        if (last_step) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // back to idle on the edge that hands off the result
        if (resp_done) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // state and step counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        step <= '0;
      end else if (shift) begin
        step <= step + step_t'(1);
      end
    end
  end

  a_load_shift_excl: assert property (@(posedge clk) disable iff (reset)
    !(load && shift)) else $error("load and shift high together");

  // DONE is entered only from the final step and left only on the handshake
  a_resp_in_done: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> ($past(resp_val && !resp_rdy) || $past(shift && last_step)))
    else $error("resp_val outside DONE");

  // response shows up after all steps and nothing else
  a_latency: assert property (@(posedge clk) disable iff (reset)
    load |-> ##(MUL_STEPS + 1) resp_val) else $error("multiply latency broken");

endmodule

// File: imul_iter_dpath.sv
// datapath of the iterative multiplier
// sign/magnitude split, shift-and-add over magnitudes, sign fix-up on output
module imul_iter_dpath
  import imul_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  // operands from the queue head
  input  word_t  q_a,
  input  word_t  q_b,

  // controls from the FSM
  input  logic   load,
  input  logic   shift,

  output dword_t resp_result
);

  // captured signs
  logic   sign_a;
  logic   sign_b;

  // multiplicand widened to 64 bits, shifts left each step
  dword_t mcand;
  // multiplier magnitude, shifts right each step
  word_t  mplier;
  // running sum of partial products
  dword_t acc;

  word_t  mag_a;
  word_t  mag_b;
  dword_t acc_sum;
  logic   neg;

  // ------------------------------
  // magnitude conversion
  // ------------------------------
  // most negative input maps to 2^31, which still fits unsigned
  assign mag_a = q_a[WORD_W-1] ? (~q_a + word_t'(1)) : q_a;
  assign mag_b = q_b[WORD_W-1] ? (~q_b + word_t'(1)) : q_b;

  // add only when current multiplier bit is set
  assign acc_sum = mplier[0] ? (acc + mcand) : acc;

  // ------------------------------
  // operand shift registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{WORD_W{1'b0}}, mag_a};
      mplier <= mag_b;
    end else if (shift) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // ------------------------------
  // accumulator and signs
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
      acc    <= '0;
    end else if (load) begin
      sign_a <= q_a[WORD_W-1];
      sign_b <= q_b[WORD_W-1];
      // fresh product starts from zero
      acc    <= '0;
    end else if (shift) begin
      acc    <= acc_sum;
    end
  end

  // ------------------------------
  // sign fix-up
  // ------------------------------
  // product is negative when exactly one operand was
  assign neg = sign_a ^ sign_b;

  // acc is frozen outside calc, so the result holds through DONE
  assign resp_result = neg ? (~acc + dword_t'(1)) : acc;

endmodule

// File: imul_iter_mul.sv
// iterative signed multiplier with valid/ready request and response ports
// control unit and datapath joined by the load and shift strobes
module imul_iter_mul
  import imul_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  // request from the queue
  input  word_t  q_a,
  input  word_t  q_b,
  input  logic   q_val,
  output logic   q_rdy,

  // response to the requester
  output dword_t resp_result,
  output logic   resp_val,
  input  logic   resp_rdy
);

  // ctrl -> dpath strobes
  logic load;
  logic shift;

  imul_iter_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .q_val    (q_val),
    .q_rdy    (q_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .shift    (shift)
  );

  imul_iter_dpath dpath (
    .clk         (clk),
    .reset       (reset),
    .q_a         (q_a),
    .q_b         (q_b),
    .load        (load),
    .shift       (shift),
    .resp_result (resp_result)
  );

  // a stalled response must not change under the consumer
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_result))
    else $error("resp_result changed while stalled");

endmodule

// File: imul_pkg.sv
// shared widths, queue depth and FSM encoding for the signed multiply unit
// imported by wildcard into every RTL module of the multiply subsystem
package imul_pkg;

  // ------------------------------
  // word widths
  // ------------------------------
  localparam int WORD_W  = 32;
  localparam int DWORD_W = 2 * WORD_W;

  // one signed operand
  typedef logic [WORD_W-1:0] word_t;
  // full signed product
  typedef logic [DWORD_W-1:0] dword_t;

  // ------------------------------
  // request queue
  // ------------------------------
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

  // read and write pointers, wrap naturally at QUEUE_DEPTH
  typedef logic [QPTR_W-1:0] qptr_t;
  // occupancy needs one more bit to hold the full count
  typedef logic [QPTR_W:0] qcount_t;

  // ------------------------------
  // iterative multiplier
  // ------------------------------
  // one shift-and-add step per multiplier bit
  localparam int MUL_STEPS = WORD_W;
  localparam int STEP_W    = $clog2(MUL_STEPS);

  typedef logic [STEP_W-1:0] step_t;

  // idle waits for a request, calc runs the steps, done holds the result
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } mul_state_e;

endpackage

// File: imul_req_queue.sv
// four-entry circular request queue holding operand pairs
// valid/ready on the push side and on the pop side, no fall-through path
module imul_req_queue
  import imul_pkg::*;
(
  input  logic  clk,
  input  logic  reset,

  // push side, from the requester
  input  word_t req_a,
  input  word_t req_b,
  input  logic  req_val,
  output logic  req_rdy,

  // pop side, oldest entry toward the multiplier
  output word_t q_a,
  output word_t q_b,
  output logic  q_val,
  input  logic  q_rdy
);

  // operand storage
  word_t   mem_a [QUEUE_DEPTH];
  word_t   mem_b [QUEUE_DEPTH];

  qptr_t   wr_ptr;
  qptr_t   rd_ptr;
  qcount_t count;

  logic    push;
  logic    pop;

  // ------------------------------
  // handshakes
  // ------------------------------
  assign req_rdy = (count != qcount_t'(QUEUE_DEPTH));
  assign q_val   = (count != '0);

  assign push = req_val && req_rdy;
  assign pop  = q_val && q_rdy;

  // head entry is always presented, qualified by q_val
  assign q_a = mem_a[rd_ptr];
  assign q_b = mem_b[rd_ptr];

  // payload array, written on push only
  always_ff @(posedge clk) begin
    if (push) begin
      mem_a[wr_ptr] <= req_a;
      mem_b[wr_ptr] <= req_b;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + qptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + qptr_t'(1);
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + qcount_t'(1);
        2'b01:   count <= count - qcount_t'(1);
        default: count <= count;
      endcase
    end
  end

  // an underflow would wrap to a large count, so one bound covers both ends
  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= qcount_t'(QUEUE_DEPTH))
    else $error("request queue count out of range: %0d", count);

endmodule

// File: imul_tb.sv
// testbench for the signed multiply subsystem, reads operand pairs and products from a file
// drives requests through the queue and checks every response in request order
module imul_tb;
  import imul_pkg::*;

  // ------------------------------
  // limits and modes
  // ------------------------------
  localparam int CYCLE_LIMIT = 1000;
  localparam int DRAIN_LIMIT = 4000;
  localparam int MIN_LATENCY = 34;
  // queue entries plus the one in flight
  localparam int BURST_LEN   = QUEUE_DEPTH + 1;

  localparam logic [1:0] RDY_LOW    = 2'd0;
  localparam logic [1:0] RDY_HIGH   = 2'd1;
  localparam logic [1:0] RDY_RANDOM = 2'd2;

  logic   clk;
  logic   reset;
  word_t  req_a;
  word_t  req_b;
  logic   req_val;
  logic   req_rdy;
  dword_t resp_result;
  logic   resp_val;
  logic   resp_rdy;

  // vectors from the file and products still owed by the DUT
  word_t  vec_a [$];
  word_t  vec_b [$];
  dword_t vec_p [$];
  dword_t exp_q [$];

  logic [1:0] rdy_mode;
  int         n_checked;
  logic       held_valid;
  dword_t     held_result;
  dword_t     exp_val;

  imul_top DUT (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #5 clk = ~clk;

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic stop_run;
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_product(input dword_t got, input dword_t exp);
    if (got !== exp) begin
      $display("ERR resp_result got %h expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // comment and blank lines fail the scan and are skipped
  task automatic load_vectors;
    int     fd;
    int     rc;
    string  line;
    word_t  a;
    word_t  b;
    dword_t p;
    fd = $fopen("imul_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file imul_vectors.txt");
      stop_run();
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 0 && $sscanf(line, "%h %h %h", a, b, p) == 3) begin
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_p.push_back(p);
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
  endtask

  // holds the request until the edge where req_rdy is seen
  task automatic push_req(input int idx);
    int waited;
    waited = 0;
    req_a   <= vec_a[idx];
    req_b   <= vec_b[idx];
    req_val <= 1'b1;
    @(posedge clk);
    while (!req_rdy) begin
      waited++;
      if (waited > CYCLE_LIMIT) begin
        $display("timeout, request %0d was never accepted", idx);
        stop_run();
      end
      @(posedge clk);
    end
    exp_q.push_back(vec_p[idx]);
  endtask

  task automatic wait_drain;
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > DRAIN_LIMIT) begin
        $display("timeout, %0d responses never arrived", exp_q.size());
        stop_run();
      end
      @(posedge clk);
    end
  endtask

  // ------------------------------
  // response side
  // ------------------------------
  // back-pressure pattern follows the mode set by the stimulus
  always @(posedge clk) begin
    case (rdy_mode)
      RDY_HIGH:   resp_rdy <= 1'b1;
      RDY_RANDOM: resp_rdy <= ($urandom_range(1, 0) == 1);
      default:    resp_rdy <= 1'b0;
    endcase
  end

  // scoreboard plus stall stability, all sampled at the edge
  always @(posedge clk) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else begin
      if (held_valid) begin
        check_flag("resp_val", resp_val, 1'b1);
        check_product(resp_result, held_result);
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          $display("a response arrived with no request outstanding");
          stop_run();
        end
        exp_val = exp_q.pop_front();
        check_product(resp_result, exp_val);
        n_checked++;
      end
      held_valid  <= resp_val && !resp_rdy;
      held_result <= resp_result;
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    int cycles;
    int gap;
    int n;
    clk        = 1'b0;
    reset      = 1'b1;
    req_a      = '0;
    req_b      = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    rdy_mode   = RDY_LOW;
    n_checked  = 0;
    held_valid = 1'b0;
    void'($urandom(32'h7662baff));
    load_vectors();
    n = vec_a.size();
    if (n < BURST_LEN + 2) begin
      $display("vector file holds only %0d vectors", n);
      stop_run();
    end

    idle_cycles(5);
    reset <= 1'b0;
    @(posedge clk);
    // idle ports straight out of reset
    check_flag("resp_val", resp_val, 1'b0);
    check_flag("req_rdy", req_rdy, 1'b1);

    // single request into an empty queue, no back-pressure
    rdy_mode <= RDY_HIGH;
    idle_cycles(2);
    push_req(0);
    req_val <= 1'b0;
    cycles = 0;
    while (!resp_val) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        $display("timeout, no response to the first request");
        stop_run();
      end
      @(posedge clk);
    end
    if (cycles < MIN_LATENCY) begin
      $display("response came %0d cycles after the request, too early", cycles);
      stop_run();
    end
    wait_drain();

    // bulk of the vectors with random gaps and random back-pressure
    rdy_mode <= RDY_RANDOM;
    for (int i = 1; i < n - BURST_LEN; i++) begin
      push_req(i);
      gap = int'($urandom_range(2, 0));
      if (gap > 0) begin
        req_val <= 1'b0;
        idle_cycles(gap);
      end
    end
    req_val <= 1'b0;
    wait_drain();

    // burst against a stalled response port fills the queue
    rdy_mode <= RDY_LOW;
    idle_cycles(2);
    for (int i = n - BURST_LEN; i < n; i++) begin
      push_req(i);
    end
    req_val <= 1'b0;
    cycles = 0;
    while (req_rdy || !resp_val) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        $display("timeout, req_rdy never dropped under back-pressure");
        stop_run();
      end
      @(posedge clk);
    end
    // hold the stall so the result is watched for changes
    idle_cycles(8);
    check_flag("req_rdy", req_rdy, 1'b0);
    rdy_mode <= RDY_HIGH;
    wait_drain();
    idle_cycles(4);

    if (exp_q.size() == 0 && n_checked == n) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("only %0d of %0d responses were checked", n_checked, n);
      stop_run();
    end
  end

endmodule

// File: imul_top.sv
// signed 32x32 multiply subsystem for the execute stage
// requests queue up four deep ahead of one iterative multiplier
module imul_top
  import imul_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  // ------------------------------
  // request port
  // ------------------------------
  input  word_t  req_a,
  input  word_t  req_b,
  input  logic   req_val,
  output logic   req_rdy,

  // ------------------------------
  // response port
  // ------------------------------
  output dword_t resp_result,
  output logic   resp_val,
  input  logic   resp_rdy
);

  // queue head toward the multiplier
  word_t q_a;
  word_t q_b;
  logic  q_val;
  logic  q_rdy;

  // buffers requests while a multiply is in flight
  imul_req_queue queue (
    .clk     (clk),
    .reset   (reset),
    .req_a   (req_a),
    .req_b   (req_b),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .q_a     (q_a),
    .q_b     (q_b),
    .q_val   (q_val),
    .q_rdy   (q_rdy)
  );

  // one multiply at a time, results leave in request order
  imul_iter_mul mul (
    .clk         (clk),
    .reset       (reset),
    .q_a         (q_a),
    .q_b         (q_b),
    .q_val       (q_val),
    .q_rdy       (q_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

endmodule

// File: imul_vectors.txt
// columns: operand a, operand b, expected signed 64-bit product a * b
// all values in hex, two's complement
00000000 00000000 0000000000000000
00000001 00000001 0000000000000001
ffffffff ffffffff 0000000000000001
00000001 ffffffff ffffffffffffffff
ffffffff 00000001 ffffffffffffffff
80000000 80000000 4000000000000000
80000000 ffffffff 0000000080000000
ffffffff 80000000 0000000080000000
7fffffff 7fffffff 3fffffff00000001
7fffffff 80000000 c000000080000000
80000000 00000001 ffffffff80000000
00000000 80000000 0000000000000000
12345678 00000010 0000000123456780
00000003 00000007 0000000000000015
fffffffd 00000007 ffffffffffffffeb
00000003 fffffff9 ffffffffffffffeb
fffffffd fffffff9 0000000000000015
00010000 00010000 0000000100000000
ffff0000 00010000 ffffffff00000000
0000ffff 0000ffff 00000000fffe0001
ffffffff 7fffffff ffffffff80000001
000003e8 000003e8 00000000000f4240
fffffc18 000003e8 fffffffffff0bdc0
deadbeef 00000000 0000000000000000
00000002 40000000 0000000080000000
fffffffe 40000000 ffffffff80000000
01000000 01000000 0001000000000000
00000005 ffff0000 fffffffffffb0000
0000abcd 00000100 0000000000abcd00
00000011 00000011 0000000000000121
